//--- source/simplePkg.sv
package simplePkg;

   // register address width, eight registers
   localparam int regAddrWidth = 3;

   // instruction class, bits 15:14
   typedef enum logic [1:0] {
      classLoad  = 2'b00,
      classStore = 2'b01,
      classImmBr = 2'b10,
      classArith = 2'b11
   } instrClass_t;

   // ALU function codes
   typedef enum logic [3:0] {
      aluAdd = 4'b0000,
      aluSub = 4'b0001,
      aluAnd = 4'b0010,
      aluOr  = 4'b0011,
      aluXor = 4'b0100,
      aluSll = 4'b1000,
      aluSlr = 4'b1001,
      aluSrl = 4'b1010,
      aluSra = 4'b1011,
      aluIdt = 4'b1100,
      aluNon = 4'b1111
   } aluSel_t;

   // one 16-bit word, read as register or immediate/branch format
   typedef union packed {
      // register format
      struct packed {
         instrClass_t             iClass;
         logic [regAddrWidth-1:0] rs;
         logic [regAddrWidth-1:0] rd;
         logic [3:0]              funct;
         logic [3:0]              low;
      } rFmt;
      // immediate, branch and stack format
      struct packed {
         logic [4:0] opcode5;
         logic [2:0] rbCond;
         logic [7:0] imm8;
      } iFmt;
   } instrWord_t;

endpackage

//--- source/controlDecoder.sv
`timescale 1ns/1ps

module controlDecoder (
   input  simplePkg::instrWord_t               command,
   output simplePkg::aluSel_t                  aluSelect,
   output logic [simplePkg::regAddrWidth-1:0]  writeAddress,
   output logic [2:0]                          cond,
   output logic [simplePkg::regAddrWidth-1:0]  op2,
   output logic                                regWrite,
   output logic                                memWrite,
   output logic                                pcLoad,
   output logic                                inputSel,
   output logic                                adrSel,
   output logic                                arSel,
   output logic                                brSel,
   output logic                                signExtend,
   output logic                                spcSel,
   output logic                                abSel,
   output logic                                mwSel,
   output logic                                spSwap,
   output logic                                madSel,
   output logic                                spInc,
   output logic                                spDec,
   output logic                                spWrite,
   output logic                                readsA,
   output logic                                readsB,
   output logic                                producer
);

   import simplePkg::*;

   // class 10 sub-opcodes
   localparam logic [4:0] opLi     = 5'b10000;
   localparam logic [4:0] opAddi   = 5'b10001;
   localparam logic [4:0] opPush   = 5'b10010;
   localparam logic [4:0] opCall   = 5'b10011;
   localparam logic [4:0] opBranch = 5'b10100;
   localparam logic [4:0] opPop    = 5'b10101;
   localparam logic [4:0] opMemImm = 5'b10110;
   localparam logic [4:0] opCondBr = 5'b10111;

   // class 11 function codes with special handling
   localparam logic [3:0] functCmp = 4'b0101;
   localparam logic [3:0] functMov = 4'b0110;
   localparam logic [3:0] functIn  = 4'b1100;

   logic       isLoad;
   logic       isStore;
   logic       isImmBr;
   logic       isArith;
   logic [3:0] funct;
   logic [4:0] opcode;
   logic       spStoreWord;
   logic       spLoadWord;

   assign isLoad  = command.rFmt.iClass == classLoad;
   assign isStore = command.rFmt.iClass == classStore;
   assign isImmBr = command.rFmt.iClass == classImmBr;
   assign isArith = command.rFmt.iClass == classArith;
   assign funct   = command.rFmt.funct;
   assign opcode  = command.iFmt.opcode5;

   // cond codes 11x under 10111 are stack accesses, not branches
   assign spStoreWord = (opcode == opCondBr) && (command.iFmt.rbCond == 3'b110);
   assign spLoadWord  = (opcode == opCondBr) && (command.iFmt.rbCond == 3'b111);

   always_comb begin
      if (isArith) begin
         case (funct)
            functCmp: aluSelect = aluSub;
            functMov: aluSelect = aluIdt;
            default:  aluSelect = aluSel_t'(funct);
         endcase
      end else if (isLoad || isStore) begin
         // address = base + offset
         aluSelect = aluAdd;
      end else if (opcode == opLi) begin
         aluSelect = aluIdt;
      end else if (opcode == opAddi || opcode == opBranch || opcode == opCondBr) begin
         aluSelect = aluAdd;
      end else begin
         aluSelect = aluNon;
      end
   end

   // load writes the field at 13:11
   assign writeAddress = isLoad ? command.rFmt.rs : command.rFmt.rd;
   assign cond         = command.iFmt.rbCond;
   assign op2          = command.rFmt.rs;

   assign regWrite = (isArith && funct <= functIn && funct != functCmp)
                   || isLoad
                   || (opcode[4:1] == 4'b1000)
                   || (opcode == opPop);

   assign memWrite = isStore || (opcode == opPush) || (opcode == opMemImm) || spStoreWord;

   assign pcLoad     = (opcode == opBranch) || (opcode == opCondBr);
   assign inputSel   = isArith && (funct == functIn);
   assign adrSel     = (isArith && funct <= 4'b1011) || isImmBr;
   assign arSel      = isArith && (funct <= functMov);
   assign brSel      = !(isImmBr && command[13]);
   assign signExtend = !isArith;

   // stack pointer and stack address muxes
   assign spcSel  = opcode == opCall;
   assign abSel   = isStore;
   assign mwSel   = !spStoreWord;
   assign spSwap  = !spLoadWord;
   assign madSel  = !((opcode == opPush) || spStoreWord || spLoadWord);
   assign spInc   = opcode == opPush;
   assign spDec   = spLoadWord;
   assign spWrite = opcode == opCall;

   // forwarding qualifiers, decoded once for all slots
   assign readsA = (isArith && (funct <= functMov || funct == 4'b1101)) || isStore;

   assign readsB = (isArith && (funct <= functCmp || (funct >= 4'b1000 && funct <= 4'b1011)))
                 || isLoad
                 || isStore;

   assign producer = isArith && funct <= functIn && funct != functCmp && funct != 4'b0111;

endmodule

//--- source/historySlot.sv
`timescale 1ns/1ps

module historySlot (
   input  logic                  clk,
   input  logic                  rstN,
   input  logic                  advance,
   input  simplePkg::instrWord_t inWord,
   input  logic                  inProducer,
   input  logic                  inValid,
   input  simplePkg::instrWord_t command,
   input  logic                  readsA,
   input  logic                  readsB,
   output simplePkg::instrWord_t heldWord,
   output logic                  heldProducer,
   output logic                  heldValid,
   output logic                  hitA,
   output logic                  hitB
);

   import simplePkg::*;

   logic [regAddrWidth-1:0] srcField;
   logic                    liveProducer;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         heldValid <= 1'b0;
      end else if (advance) begin
         heldValid <= inValid;
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         heldWord     <= inWord;
         heldProducer <= inProducer;
      end
   end

   // current word names its source at 10:8
   assign srcField     = command.rFmt.rd;
   assign liveProducer = heldValid && heldProducer;

   // port A result sits at 13:11, port B at 10:8
   assign hitA = liveProducer && readsA && (srcField == heldWord.rFmt.rs);
   assign hitB = liveProducer && readsB && (srcField == heldWord.rFmt.rd);

endmodule

//--- source/forwardSelect.sv
`timescale 1ns/1ps

module forwardSelect #(
   parameter int forwardDepth = 2
) (
   input  logic [forwardDepth-1:0] hitA,
   input  logic [forwardDepth-1:0] hitB,
   output logic [forwardDepth-1:0] fwdSelA,
   output logic [forwardDepth-1:0] fwdSelB
);

   // keep the lowest set bit, slot 0 is the nearest producer
   function automatic logic [forwardDepth-1:0] nearestHit(
      input logic [forwardDepth-1:0] hits
   );
      logic [forwardDepth-1:0] sel;
      logic                    found;
      sel   = '0;
      found = 1'b0;
      for (int k = 0; k < forwardDepth; k++) begin
         if (hits[k] && !found) begin
            sel[k] = 1'b1;
            found  = 1'b1;
         end
      end
      return sel;
   endfunction

   assign fwdSelA = nearestHit(hitA);
   assign fwdSelB = nearestHit(hitB);

endmodule

//--- source/simpleDecodeStage.sv
`timescale 1ns/1ps

module simpleDecodeStage #(
   parameter int forwardDepth = 2
) (
   input  logic                               clk,
   input  logic                               rstN,
   input  simplePkg::instrWord_t              command,
   input  logic                               advance,
   output simplePkg::aluSel_t                 aluSelect,
   output logic [simplePkg::regAddrWidth-1:0] writeAddress,
   output logic [2:0]                         cond,
   output logic [simplePkg::regAddrWidth-1:0] op2,
   output logic                               regWrite,
   output logic                               memWrite,
   output logic                               pcLoad,
   output logic                               inputSel,
   output logic                               adrSel,
   output logic                               arSel,
   output logic                               brSel,
   output logic                               signExtend,
   output logic                               spcSel,
   output logic                               abSel,
   output logic                               mwSel,
   output logic                               spSwap,
   output logic                               madSel,
   output logic                               spInc,
   output logic                               spDec,
   output logic                               spWrite,
   output logic [forwardDepth-1:0]            fwdSelA,
   output logic [forwardDepth-1:0]            fwdSelB
);

   import simplePkg::*;

   instrWord_t              chainWord [forwardDepth+1];
   logic [forwardDepth:0]   chainProducer;
   logic [forwardDepth:0]   chainValid;
   logic [forwardDepth-1:0] hitA;
   logic [forwardDepth-1:0] hitB;
   logic                    readsA;
   logic                    readsB;
   logic                    producer;

   // head of the chain is the word being decoded now
   assign chainWord[0]     = command;
   assign chainProducer[0] = producer;
   assign chainValid[0]    = 1'b1;

   controlDecoder u_controlDecoder (
      .command      (command),
      .aluSelect    (aluSelect),
      .writeAddress (writeAddress),
      .cond         (cond),
      .op2          (op2),
      .regWrite     (regWrite),
      .memWrite     (memWrite),
      .pcLoad       (pcLoad),
      .inputSel     (inputSel),
      .adrSel       (adrSel),
      .arSel        (arSel),
      .brSel        (brSel),
      .signExtend   (signExtend),
      .spcSel       (spcSel),
      .abSel        (abSel),
      .mwSel        (mwSel),
      .spSwap       (spSwap),
      .madSel       (madSel),
      .spInc        (spInc),
      .spDec        (spDec),
      .spWrite      (spWrite),
      .readsA       (readsA),
      .readsB       (readsB),
      .producer     (producer)
   );

   // slot k holds the word decoded k+1 advances ago
   for (genvar k = 0; k < forwardDepth; k++) begin : gSlot
      historySlot u_historySlot (
         .clk          (clk),
         .rstN         (rstN),
         .advance      (advance),
         .inWord       (chainWord[k]),
         .inProducer   (chainProducer[k]),
         .inValid      (chainValid[k]),
         .command      (command),
         .readsA       (readsA),
         .readsB       (readsB),
         .heldWord     (chainWord[k+1]),
         .heldProducer (chainProducer[k+1]),
         .heldValid    (chainValid[k+1]),
         .hitA         (hitA[k]),
         .hitB         (hitB[k])
      );
   end

   forwardSelect #(
      .forwardDepth (forwardDepth)
   ) u_forwardSelect (
      .hitA    (hitA),
      .hitB    (hitB),
      .fwdSelA (fwdSelA),
      .fwdSelB (fwdSelB)
   );

endmodule

//--- tests/simpleDecodeStage_properties.sv
`timescale 1ns/1ps

module simpleDecodeStage_properties #(
   parameter int forwardDepth = 2
) (
   input logic                    clk,
   input logic                    rstN,
   input logic [forwardDepth-1:0] fwdSelA,
   input logic [forwardDepth-1:0] fwdSelB,
   input logic                    spInc,
   input logic                    spDec
);

   // only the nearest producer may drive a port
   selAOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(fwdSelA))
      else $error("fwdSelA selects more than one slot");

   selBOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(fwdSelB))
      else $error("fwdSelB selects more than one slot");

   stackOneWay: assert property (@(posedge clk) disable iff (!rstN) !(spInc && spDec))
      else $error("spInc and spDec are high together");

   // history is empty right after reset
   selClearAfterReset: assert property (@(posedge clk)
      $rose(rstN) |-> (fwdSelA == '0 && fwdSelB == '0))
      else $error("forwarding select set in the first cycle after reset");

endmodule

bind simpleDecodeStage simpleDecodeStage_properties #(
   .forwardDepth (forwardDepth)
) u_simpleDecodeStageProperties (
   .clk     (clk),
   .rstN    (rstN),
   .fwdSelA (fwdSelA),
   .fwdSelB (fwdSelB),
   .spInc   (spInc),
   .spDec   (spDec)
);

//--- tests/simpleDecodeStage_tb.sv
`timescale 1ns/1ps

module simpleDecodeStage_tb;

   import simplePkg::*;

   localparam int depth = 2;
   localparam int testCycles = 112;
   localparam int marginCycles = 60;

   logic                    clk;
   logic                    rstN;
   logic                    advance;
   instrWord_t              command;
   aluSel_t                 aluSelect;
   logic [regAddrWidth-1:0] writeAddress;
   logic [2:0]              cond;
   logic [regAddrWidth-1:0] op2;
   logic                    regWrite;
   logic                    memWrite;
   logic                    pcLoad;
   logic                    inputSel;
   logic                    adrSel;
   logic                    arSel;
   logic                    brSel;
   logic                    signExtend;
   logic                    spcSel;
   logic                    abSel;
   logic                    mwSel;
   logic                    spSwap;
   logic                    madSel;
   logic                    spInc;
   logic                    spDec;
   logic                    spWrite;
   logic [depth-1:0]        fwdSelA;
   logic [depth-1:0]        fwdSelB;

   // shadow of the DUT history, slot 0 nearest
   logic [15:0] histWord [depth];
   logic        histValid [depth];
   logic [15:0] curWord;
   logic        curAdv;

   simpleDecodeStage #(.forwardDepth(depth)) u_simpleDecodeStage (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      #((testCycles + marginCycles) * 10);
      $display("watchdog expired before the tests completed");
      $display("*** FAILED ***");
      $fatal(1, "timeout");
   end

   task automatic expectEqual(input string name, input logic [15:0] observed,
                              input logic [15:0] expected);
      if (observed !== expected) begin
         $display("** Error at %0t ns: %s observed 0x%0h expected 0x%0h",
                  $time, name, observed, expected);
         $display("*** FAILED ***");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   function automatic logic isProducer(input logic [15:0] w);
      return w[15:14] == 2'b11 && w[7:4] <= 4'b1100 && w[7:4] != 4'b0101 && w[7:4] != 4'b0111;
   endfunction

   function automatic logic readsPort(input logic [15:0] w, input logic portB);
      if (portB)
         return (w[15:14] == 2'b11 && (w[7:4] <= 4'b0101 || w[7:6] == 2'b10)) || !w[15];
      return (w[15:14] == 2'b11 && (w[7:4] <= 4'b0110 || w[7:4] == 4'b1101))
             || w[15:14] == 2'b01;
   endfunction

   // walk far to near so the nearest match is kept
   function automatic logic [depth-1:0] modelSel(input logic [15:0] w, input logic portB);
      logic [depth-1:0] sel;
      logic [2:0]       dest;
      sel = '0;
      for (int k = depth - 1; k >= 0; k--) begin
         dest = portB ? histWord[k][10:8] : histWord[k][13:11];
         if (histValid[k] && isProducer(histWord[k]) && readsPort(w, portB)
             && dest == w[10:8]) begin
            sel = '0;
            sel[k] = 1'b1;
         end
      end
      return sel;
   endfunction

   function automatic logic [15:0] arithWord(input logic [3:0] f, input logic [2:0] s,
                                             input logic [2:0] d);
      return {2'b11, s, d, f, 4'b0000};
   endfunction

   task automatic clearHistory();
      for (int k = 0; k < depth; k++) begin
         histWord[k] = '0;
         histValid[k] = 1'b0;
      end
   endtask

   task automatic present(input logic [15:0] w, input logic adv);
      command = w;
      advance = adv;
      curWord = w;
      curAdv = adv;
      #2;
      expectEqual("fwdSelA", 16'(fwdSelA), 16'(modelSel(w, 1'b0)));
      expectEqual("fwdSelB", 16'(fwdSelB), 16'(modelSel(w, 1'b1)));
   endtask

   task automatic nextCycle();
      @(posedge clk);
      #1;
      if (curAdv) begin
         for (int k = depth - 1; k > 0; k--) begin
            histWord[k] = histWord[k-1];
            histValid[k] = histValid[k-1];
         end
         histWord[0] = curWord;
         histValid[0] = 1'b1;
      end
   endtask

   task automatic shiftIn(input logic [15:0] w);
      present(w, 1'b1);
      nextCycle();
   endtask

   // two load-immediate words push older history out
   task automatic flush();
      shiftIn(16'h8000);
      shiftIn(16'h8000);
   endtask

   task automatic expectSel(input logic [depth-1:0] a, input logic [depth-1:0] b);
      expectEqual("fwdSelA", 16'(fwdSelA), 16'(a));
      expectEqual("fwdSelB", 16'(fwdSelB), 16'(b));
   endtask

   // op2 is the field at 13:11, cond the field at 10:8
   task automatic checkWrite(input logic [2:0] addr, input logic [2:0] s, input logic [2:0] d,
                             input logic [6:0] flags);
      expectEqual("writeAddress", 16'(writeAddress), 16'(addr));
      expectEqual("op2", 16'(op2), 16'(s));
      expectEqual("cond", 16'(cond), 16'(d));
      expectEqual("writeFlags",
                  16'({regWrite, memWrite, signExtend, arSel, brSel, adrSel, abSel}),
                  16'(flags));
   endtask

   task automatic stackCase(input logic [15:0] w, input logic [7:0] expected);
      present(w, 1'b0);
      expectEqual("stackCtl", 16'({spInc, spDec, spWrite, spSwap, madSel, mwSel, spcSel, pcLoad}),
                  16'(expected));
      nextCycle();
   endtask

   task automatic resetHoldTest(input logic [15:0] prod, input logic [15:0] cons);
      present(cons, 1'b0);
      expectSel(2'b00, 2'b00);
      nextCycle();
      shiftIn(prod);
      repeat (5) begin
         present(cons, 1'b0);
         expectSel(2'b01, 2'b01);
         nextCycle();
      end
      shiftIn(16'h8000);
      present(cons, 1'b0);
      expectSel(2'b10, 2'b10);
      nextCycle();
      // reset while the history is full
      rstN = 1'b0;
      clearHistory();
      present(cons, 1'b0);
      expectSel(2'b00, 2'b00);
      nextCycle();
      rstN = 1'b1;
      present(cons, 1'b0);
      expectSel(2'b00, 2'b00);
      nextCycle();
   endtask

   task automatic aluTest();
      logic [3:0] f;
      logic [3:0] expAlu;
      logic [4:0] op;
      for (int i = 0; i < 16; i++) begin
         f = 4'(i);
         expAlu = (f == 4'b0101) ? 4'b0001 : (f == 4'b0110) ? 4'b1100 : f;
         present(arithWord(f, 3'd1, 3'd2), 1'b0);
         expectEqual("aluSelect", 16'(aluSelect), 16'(expAlu));
         expectEqual("inputSel", 16'(inputSel), 16'(f == 4'b1100));
         nextCycle();
      end
      for (int i = 16; i < 24; i++) begin
         op = 5'(i);
         case (op)
            5'b10000: expAlu = 4'b1100;
            5'b10001, 5'b10100, 5'b10111: expAlu = 4'b0000;
            default: expAlu = 4'b1111;
         endcase
         present({op, 3'b000, 8'h3c}, 1'b0);
         expectEqual("aluSelect", 16'(aluSelect), 16'(expAlu));
         expectEqual("inputSel", 16'(inputSel), 16'h0000);
         nextCycle();
      end
   endtask

   task automatic writeTest();
      logic [2:0] s;
      logic [2:0] d;
      for (int i = 0; i < 8; i++) begin
         s = 3'($urandom());
         d = 3'($urandom());
         present({2'b00, s, d, 8'($urandom())}, 1'b0);
         checkWrite(s, s, d, 7'b1010100);
         nextCycle();
         present({2'b01, s, d, 8'($urandom())}, 1'b0);
         checkWrite(d, s, d, 7'b0110101);
         nextCycle();
         present(arithWord(4'b0000, s, d), 1'b0);
         checkWrite(d, s, d, 7'b1001110);
         nextCycle();
      end
   endtask

   // order is spInc spDec spWrite spSwap madSel mwSel spcSel pcLoad
   task automatic stackTest();
      stackCase({5'b10010, 3'b000, 8'h00}, 8'b10010100);
      stackCase({5'b10101, 3'b010, 8'h00}, 8'b00011100);
      stackCase({5'b10011, 3'b000, 8'h40}, 8'b00111110);
      stackCase({5'b10100, 3'b000, 8'h08}, 8'b00011101);
      stackCase({5'b10111, 3'b000, 8'h08}, 8'b00011101);
      stackCase({5'b10111, 3'b110, 8'h00}, 8'b00010001);
      stackCase({5'b10111, 3'b111, 8'h00}, 8'b01000101);
   endtask

   task automatic fwdTest(input logic [15:0] prod, input logic [15:0] cons,
                          input logic [15:0] split);
      flush();
      shiftIn(prod);
      present(cons, 1'b0);
      expectSel(2'b01, 2'b01);
      nextCycle();
      flush();
      shiftIn(prod);
      shiftIn(16'h8000);
      present(cons, 1'b0);
      expectSel(2'b10, 2'b10);
      nextCycle();
      flush();
      shiftIn(prod);
      shiftIn(prod);
      present(cons, 1'b0);
      expectSel(2'b01, 2'b01);
      nextCycle();
      // result fields differ, so only port A matches
      flush();
      shiftIn(split);
      present(cons, 1'b0);
      expectSel(2'b01, 2'b00);
      nextCycle();
   endtask

   task automatic nonProducerTest(input logic [2:0] r, input logic [15:0] cons);
      flush();
      shiftIn(arithWord(4'b0101, r, r));
      present(cons, 1'b0);
      expectSel(2'b00, 2'b00);
      nextCycle();
      flush();
      shiftIn({2'b01, r, r, 8'h00});
      present(cons, 1'b0);
      expectSel(2'b00, 2'b00);
      nextCycle();
      flush();
      shiftIn({2'b10, r, r, 8'h00});
      present(cons, 1'b0);
      expectSel(2'b00, 2'b00);
      nextCycle();
      flush();
      shiftIn(arithWord(4'b0000, r, r));
      present(arithWord(4'b0111, r, r), 1'b0);
      expectSel(2'b00, 2'b00);
      nextCycle();
      // shift reads port B only
      present(arithWord(4'b1000, r, r), 1'b0);
      expectSel(2'b00, 2'b01);
      nextCycle();
      // move reads port A only
      present(arithWord(4'b0110, r, r), 1'b0);
      expectSel(2'b01, 2'b00);
      nextCycle();
   endtask

   initial begin
      logic [2:0]  r;
      logic [15:0] prod;
      logic [15:0] cons;
      logic [15:0] split;
      void'($urandom(50));
      rstN = 1'b0;
      advance = 1'b0;
      command = '0;
      curWord = '0;
      curAdv = 1'b0;
      clearHistory();
      r = 3'($urandom());
      prod = arithWord(4'b0000, r, r);
      cons = arithWord(4'b0001, r + 3'd1, r);
      split = arithWord(4'b0000, r, r + 3'd1);
      repeat (10) @(posedge clk);
      #1;
      rstN = 1'b1;
      resetHoldTest(prod, cons);
      aluTest();
      writeTest();
      stackTest();
      fwdTest(prod, cons, split);
      nonProducerTest(r, cons);
      $display("*** PASSED ***");
      $finish;
   end

endmodule

//--- project.f
source/simplePkg.sv
source/controlDecoder.sv
source/historySlot.sv
source/forwardSelect.sv
source/simpleDecodeStage.sv
tests/simpleDecodeStage_properties.sv
tests/simpleDecodeStage_tb.sv

//--- Makefile
TOP = simpleDecodeStage_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir -o simv

run: compile
	./obj_dir/simv

clean:
	rm -rf obj_dir
